// File: hdl/ntm_params.svh
////////////////////
// Sizing macros for the cell-state update datapath
// Include wherever widths or memory depth are needed
////////////////////

`ifndef NTM_PARAMS_SVH
`define NTM_PARAMS_SVH

// Element width, signed Q7.8
`define NTM_DATA_W 16

// Fraction bits of the fixed-point format
`define NTM_FRAC_W 8

// State memory depth, one word per element
`define NTM_MAX_L 16

// Element index width, log2 of NTM_MAX_L
`define NTM_IDX_W 4

`endif

// File: hdl/ntm_fixed_pkg.sv
////////////////////
// Fixed-point value types for the datapath stages
// Also used by the testbench reference model
////////////////////

`include "ntm_params.svh"

package ntm_fixed_pkg;

  ////////////////////
  // Element values
  ////////////////////

  // One signed element, Q7.8
  typedef logic signed [`NTM_DATA_W-1:0] data_t;

  ////////////////////
  // Intermediate values
  ////////////////////

  // Product after the fraction shift
  // Kept at double width, no clipping before the add
  typedef logic signed [2*`NTM_DATA_W-1:0] prod_t;

  // Sum of two products plus one guard bit
  // Saturated back to data_t afterwards
  typedef logic signed [2*`NTM_DATA_W:0] sum_t;

endpackage

// File: hdl/ntm_ctrl_pkg.sv
////////////////////
// Control types for the vector sequencer
////////////////////

`include "ntm_params.svh"

package ntm_ctrl_pkg;

  // Element position within a vector
  typedef logic [`NTM_IDX_W-1:0] idx_t;

  // Vector length, 1 up to NTM_MAX_L, one extra bit
  typedef logic [`NTM_IDX_W:0] len_t;

  // Sequencer FSM
  typedef enum logic {
    IDLE,
    RUN
  } seq_state_t;

endpackage

// File: hdl/gate_stream_if.sv
////////////////////
// One element in flight between two pipeline stages
////////////////////

`timescale 1ns/1ps

interface gate_stream_if;

  // Element valid, single cycle
  logic strobe;
  // Final element of the vector
  logic last;
  // Element position, used for the write-back
  ntm_ctrl_pkg::idx_t idx;

  // Operand pairs, sequencer to product stage
  // Pair 0 is (f, s_prev), pair 1 is (i, a)
  ntm_fixed_pkg::data_t op_a0;
  ntm_fixed_pkg::data_t op_b0;
  ntm_fixed_pkg::data_t op_a1;
  ntm_fixed_pkg::data_t op_b1;

  // Scaled products, product stage to sum stage
  ntm_fixed_pkg::prod_t p0;
  ntm_fixed_pkg::prod_t p1;

  // Driving stage
  modport src (output strobe, last, idx, op_a0, op_b0, op_a1, op_b1, p0, p1);

  // Receiving stage
  modport dst (input strobe, last, idx, op_a0, op_b0, op_a1, op_b1, p0, p1);

endinterface

// File: hdl/state_vector_seq.sv
////////////////////
// Vector sequencer and per-element state memory
// First pipeline stage, feeds operands plus s_prev downstream
////////////////////

`timescale 1ns/1ps

`include "ntm_params.svh"

module state_vector_seq (
  input  logic                      CLK,
  input  logic                      RST,
  input  logic                      START,
  input  ntm_ctrl_pkg::len_t        SIZE_L,
  input  logic                      CLEAR,
  input  logic                      IN_STROBE,
  input  ntm_fixed_pkg::data_t      I_IN,
  input  ntm_fixed_pkg::data_t      F_IN,
  input  ntm_fixed_pkg::data_t      A_IN,
  input  logic                      wb_strobe,
  input  ntm_ctrl_pkg::idx_t        wb_idx,
  input  ntm_fixed_pkg::data_t      wb_data,
  gate_stream_if.src                out
);

  ntm_ctrl_pkg::seq_state_t state;
  ntm_ctrl_pkg::len_t       len_q;
  ntm_ctrl_pkg::idx_t       idx_q;

  // s(t-1) for every element
  ntm_fixed_pkg::data_t     state_mem [`NTM_MAX_L];

  logic accept;
  logic is_last;
  logic clear_go;

  ////////////////////
  // Handshake decode
  ////////////////////

  // Elements only count while a vector is open
  assign accept   = IN_STROBE && (state == ntm_ctrl_pkg::RUN);
  // Count reaches the latched length
  assign is_last  = (ntm_ctrl_pkg::len_t'(idx_q) + 1'b1) == len_q;
  // Clear only between vectors
  assign clear_go = CLEAR && (state == ntm_ctrl_pkg::IDLE);

  ////////////////////
  // FSM and counters
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state      <= ntm_ctrl_pkg::IDLE;
      len_q      <= '0;
      idx_q      <= '0;
      out.strobe <= 1'b0;
    end else begin
      out.strobe <= accept;
      case (state)
        ntm_ctrl_pkg::IDLE: begin
          // Zero length would never close, so it is not started
          if (START && (SIZE_L != '0)) begin
            len_q <= SIZE_L;
            idx_q <= '0;
            state <= ntm_ctrl_pkg::RUN;
          end
        end
        ntm_ctrl_pkg::RUN: begin
          // START here is ignored
          if (IN_STROBE) begin
            idx_q <= idx_q + ntm_ctrl_pkg::idx_t'(1);
            if (is_last) begin
              state <= ntm_ctrl_pkg::IDLE;
            end
          end
        end
        default: begin
          state <= ntm_ctrl_pkg::IDLE;
        end
      endcase
    end
  end

  ////////////////////
  // State memory
  ////////////////////

  // CLEAR takes priority over a write-back on the same edge
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      for (int k = 0; k < `NTM_MAX_L; k++) begin
        state_mem[k] <= '0;
      end
    end else if (clear_go) begin
      for (int k = 0; k < `NTM_MAX_L; k++) begin
        state_mem[k] <= '0;
      end
    end else if (wb_strobe) begin
      state_mem[wb_idx] <= wb_data;
    end
  end

  ////////////////////
  // Operand register
  ////////////////////

  // Memory read is combinational, captured with the inputs
  always_ff @(posedge CLK) begin
    if (accept) begin
      out.op_a0 <= F_IN;
      out.op_b0 <= state_mem[idx_q];
      out.op_a1 <= I_IN;
      out.op_b1 <= A_IN;
      out.idx   <= idx_q;
      out.last  <= is_last;
    end
  end

endmodule

// File: hdl/gate_product_stage.sv
////////////////////
// Second pipeline stage, both gate products per element
////////////////////

`timescale 1ns/1ps

`include "ntm_params.svh"

module gate_product_stage (
  input  logic       CLK,
  input  logic       RST,
  gate_stream_if.dst in_s,
  gate_stream_if.src out_p
);

  // Full-width signed products, Q14.16
  ntm_fixed_pkg::prod_t prod0_full;
  ntm_fixed_pkg::prod_t prod1_full;

  // Back to 8 fraction bits
  ntm_fixed_pkg::prod_t prod0_scaled;
  ntm_fixed_pkg::prod_t prod1_scaled;

  ////////////////////
  // Multiply
  ////////////////////

  // f * s_prev
  assign prod0_full = ntm_fixed_pkg::prod_t'(in_s.op_a0) * ntm_fixed_pkg::prod_t'(in_s.op_b0);

  // i * a
  assign prod1_full = ntm_fixed_pkg::prod_t'(in_s.op_a1) * ntm_fixed_pkg::prod_t'(in_s.op_b1);

  // Arithmetic shift, rounds toward minus infinity
  assign prod0_scaled = prod0_full >>> `NTM_FRAC_W;
  assign prod1_scaled = prod1_full >>> `NTM_FRAC_W;

  ////////////////////
  // Stage register
  ////////////////////

  // Strobe only, cleared on reset
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      out_p.strobe <= 1'b0;
    end else begin
      out_p.strobe <= in_s.strobe;
    end
  end

  // Payload follows the strobe
  always_ff @(posedge CLK) begin
    if (in_s.strobe) begin
      out_p.p0   <= prod0_scaled;
      out_p.p1   <= prod1_scaled;
      out_p.idx  <= in_s.idx;
      out_p.last <= in_s.last;
    end
  end

endmodule

// File: hdl/gate_sum_stage.sv
////////////////////
// Final stage, saturating add, result output and state write-back
////////////////////

`timescale 1ns/1ps

`include "ntm_params.svh"

module gate_sum_stage (
  input  logic                 CLK,
  input  logic                 RST,
  gate_stream_if.dst           in_p,
  output logic                 S_OUT_STROBE,
  output ntm_fixed_pkg::data_t S_OUT,
  output logic                 READY,
  output logic                 wb_strobe,
  output ntm_ctrl_pkg::idx_t   wb_idx,
  output ntm_fixed_pkg::data_t wb_data
);

  // Clamp limits of data_t
  localparam ntm_fixed_pkg::data_t DATA_MAX = {1'b0, {(`NTM_DATA_W-1){1'b1}}};
  localparam ntm_fixed_pkg::data_t DATA_MIN = {1'b1, {(`NTM_DATA_W-1){1'b0}}};

  ntm_fixed_pkg::sum_t  sum_full;
  ntm_fixed_pkg::data_t sum_sat;
  ntm_ctrl_pkg::idx_t   idx_q;

  ////////////////////
  // Add and clamp
  ////////////////////

  // Guard bit keeps the add exact
  assign sum_full = ntm_fixed_pkg::sum_t'(in_p.p0) + ntm_fixed_pkg::sum_t'(in_p.p1);

  always_comb begin
    if (sum_full > ntm_fixed_pkg::sum_t'(DATA_MAX)) begin
      sum_sat = DATA_MAX;
    end else if (sum_full < ntm_fixed_pkg::sum_t'(DATA_MIN)) begin
      sum_sat = DATA_MIN;
    end else begin
      sum_sat = ntm_fixed_pkg::data_t'(sum_full);
    end
  end

  ////////////////////
  // Output register
  ////////////////////

  // S_OUT holds its last value between strobes
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      S_OUT_STROBE <= 1'b0;
      READY        <= 1'b0;
      S_OUT        <= '0;
    end else begin
      S_OUT_STROBE <= in_p.strobe;
      // Pulses once, with the last element
      READY        <= in_p.strobe && in_p.last;
      if (in_p.strobe) begin
        S_OUT <= sum_sat;
      end
    end
  end

  // Element index travels with the result
  always_ff @(posedge CLK) begin
    if (in_p.strobe) begin
      idx_q <= in_p.idx;
    end
  end

  ////////////////////
  // Write-back
  ////////////////////

  // Memory takes the registered result on the next edge
  assign wb_strobe = S_OUT_STROBE;
  assign wb_idx    = idx_q;
  assign wb_data   = S_OUT;

endmodule

// File: hdl/state_gate_vector.sv
////////////////////
// Cell-state update s = f*s_prev + i*a, one element per strobe
// Top level, three cycles from IN_STROBE to S_OUT_STROBE
////////////////////

`timescale 1ns/1ps

module state_gate_vector (
  // Clock and reset
  input  logic                 CLK,
  input  logic                 RST,

  // Vector control
  input  logic                 START,
  input  ntm_ctrl_pkg::len_t   SIZE_L,
  input  logic                 CLEAR,
  output logic                 READY,

  // Element input
  input  logic                 IN_STROBE,
  input  ntm_fixed_pkg::data_t I_IN,
  input  ntm_fixed_pkg::data_t F_IN,
  input  ntm_fixed_pkg::data_t A_IN,

  // Element output
  output logic                 S_OUT_STROBE,
  output ntm_fixed_pkg::data_t S_OUT
);

  // State write-back, sum stage to memory
  logic                 wb_strobe;
  ntm_ctrl_pkg::idx_t   wb_idx;
  ntm_fixed_pkg::data_t wb_data;

  ////////////////////
  // Stage links
  ////////////////////

  // Operands plus s_prev
  gate_stream_if seq_s ();
  // Scaled products
  gate_stream_if prod_s ();

  ////////////////////
  // Pipeline
  ////////////////////

  // Stage 1, sequencer and state memory
  state_vector_seq seq0 (
    .CLK      (CLK),
    .RST      (RST),
    .START    (START),
    .SIZE_L   (SIZE_L),
    .CLEAR    (CLEAR),
    .IN_STROBE(IN_STROBE),
    .I_IN     (I_IN),
    .F_IN     (F_IN),
    .A_IN     (A_IN),
    .wb_strobe(wb_strobe),
    .wb_idx   (wb_idx),
    .wb_data  (wb_data),
    .out      (seq_s.src)
  );

  // Stage 2, products
  gate_product_stage prod0 (
    .CLK  (CLK),
    .RST  (RST),
    .in_s (seq_s.dst),
    .out_p(prod_s.src)
  );

  // Stage 3, saturating sum and write-back
  gate_sum_stage sum0 (
    .CLK         (CLK),
    .RST         (RST),
    .in_p        (prod_s.dst),
    .S_OUT_STROBE(S_OUT_STROBE),
    .S_OUT       (S_OUT),
    .READY       (READY),
    .wb_strobe   (wb_strobe),
    .wb_idx      (wb_idx),
    .wb_data     (wb_data)
  );

endmodule

// File: sim/state_gate_vector_sva.sv
////////////////////
// Protocol and latency assertions, bound into the top level
////////////////////

`timescale 1ns/1ps

module state_gate_vector_sva (
  input logic                     CLK,
  input logic                     RST,
  input logic                     IN_STROBE,
  input ntm_ctrl_pkg::seq_state_t seq_state,
  input logic                     S_OUT_STROBE,
  input logic                     READY,
  input ntm_fixed_pkg::data_t     S_OUT
);

  // Failed assertions, read back by the testbench
  int fail_count = 0;

  logic accept;

  // Element taken only while a vector is open
  assign accept = IN_STROBE && (seq_state == ntm_ctrl_pkg::RUN);

  // Result exactly three cycles after an accepted element
  latency_a: assert property (@(posedge CLK) disable iff (RST) accept |-> ##3 S_OUT_STROBE)
    else begin
      fail_count++;
      $error("S_OUT_STROBE missing three cycles after an accepted element");
    end

  // No result without an element three cycles back
  origin_a: assert property (@(posedge CLK) disable iff (RST) S_OUT_STROBE |-> $past(accept, 3))
    else begin
      fail_count++;
      $error("S_OUT_STROBE without an accepted element three cycles earlier");
    end

  // READY only together with a result
  ready_a: assert property (@(posedge CLK) disable iff (RST) READY |-> S_OUT_STROBE)
    else begin
      fail_count++;
      $error("READY high without S_OUT_STROBE");
    end

  // Outputs quiet during reset
  reset_a: assert property (@(posedge CLK) RST |-> !S_OUT_STROBE && !READY)
    else begin
      fail_count++;
      $error("output strobe high while RST is asserted");
    end

  // Clean output right after reset release
  release_a: assert property (@(posedge CLK) $fell(RST) |-> (S_OUT == '0) && !S_OUT_STROBE && !READY)
    else begin
      fail_count++;
      $error("outputs not cleared after reset");
    end

endmodule

bind state_gate_vector state_gate_vector_sva sva0 (
  .CLK         (CLK),
  .RST         (RST),
  .IN_STROBE   (IN_STROBE),
  .seq_state   (seq0.state),
  .S_OUT_STROBE(S_OUT_STROBE),
  .READY       (READY),
  .S_OUT       (S_OUT)
);

// File: sim/state_gate_vector_tb.sv
////////////////////
// Testbench for the cell-state update top level
// Directed and random vectors against a fixed-point reference model
////////////////////

`timescale 1ns/1ps

`include "ntm_params.svh"

module state_gate_vector_tb;

  localparam ntm_fixed_pkg::data_t FULL_POS = ntm_fixed_pkg::data_t'(2**(`NTM_DATA_W-1) - 1);
  localparam ntm_fixed_pkg::data_t FULL_NEG = ntm_fixed_pkg::data_t'(-(2**(`NTM_DATA_W-1)));

  logic                 CLK;
  logic                 RST;
  logic                 START;
  ntm_ctrl_pkg::len_t   SIZE_L;
  logic                 CLEAR;
  logic                 IN_STROBE;
  ntm_fixed_pkg::data_t I_IN;
  ntm_fixed_pkg::data_t F_IN;
  ntm_fixed_pkg::data_t A_IN;
  logic                 S_OUT_STROBE;
  ntm_fixed_pkg::data_t S_OUT;
  logic                 READY;

  // Reference copy of s(t-1)
  ntm_fixed_pkg::data_t ref_mem [`NTM_MAX_L];
  // Pending results and their last flags
  ntm_fixed_pkg::data_t exp_q [$];
  logic                 last_q [$];
  ntm_fixed_pkg::data_t exp_val;
  logic                 exp_last;

  int errors = 0;
  int checks = 0;
  int issued = 0;
  int vectors = 0;
  int ready_seen = 0;
  int wd_cycles = 0;
  int cur_idx = 0;
  int cur_len = 0;
  int len;

  state_gate_vector dut0 (
    .CLK         (CLK),
    .RST         (RST),
    .START       (START),
    .SIZE_L      (SIZE_L),
    .CLEAR       (CLEAR),
    .READY       (READY),
    .IN_STROBE   (IN_STROBE),
    .I_IN        (I_IN),
    .F_IN        (F_IN),
    .A_IN        (A_IN),
    .S_OUT_STROBE(S_OUT_STROBE),
    .S_OUT       (S_OUT)
  );

  initial CLK = 1'b0;
  always #50 CLK = ~CLK;

  ////////////////////
  // Reference model
  ////////////////////

  // Scaled products summed exactly then clamped to 16 bits
  function automatic ntm_fixed_pkg::data_t cell_update(input ntm_fixed_pkg::data_t f,
      input ntm_fixed_pkg::data_t s, input ntm_fixed_pkg::data_t i,
      input ntm_fixed_pkg::data_t a);
    longint p0;
    longint p1;
    longint sum;
    p0  = (longint'(f) * longint'(s)) >>> `NTM_FRAC_W;
    p1  = (longint'(i) * longint'(a)) >>> `NTM_FRAC_W;
    sum = p0 + p1;
    if (sum > longint'(FULL_POS)) sum = longint'(FULL_POS);
    if (sum < longint'(FULL_NEG)) sum = longint'(FULL_NEG);
    return ntm_fixed_pkg::data_t'(sum);
  endfunction

  // Mostly small values with the odd full-range one
  function automatic ntm_fixed_pkg::data_t rand_operand();
    if ($urandom_range(7, 0) == 0) return ntm_fixed_pkg::data_t'($urandom);
    return ntm_fixed_pkg::data_t'(int'($urandom_range(1023, 0)) - 512);
  endfunction

  ////////////////////
  // Stimulus tasks
  ////////////////////

  // Strobes low for n cycles
  task automatic idle(input int n);
    repeat (n) begin
      @(negedge CLK);
      START = 1'b0;
      CLEAR = 1'b0;
      IN_STROBE = 1'b0;
    end
  endtask

  task automatic clear_state();
    @(negedge CLK);
    START = 1'b0;
    CLEAR = 1'b1;
    IN_STROBE = 1'b0;
    for (int k = 0; k < `NTM_MAX_L; k++) ref_mem[k] = '0;
  endtask

  task automatic start_vector(input int n);
    @(negedge CLK);
    START = 1'b1;
    CLEAR = 1'b0;
    IN_STROBE = 1'b0;
    SIZE_L = ntm_ctrl_pkg::len_t'(n);
    cur_len = n;
    cur_idx = 0;
  endtask

  // One element with an optional START that must be ignored
  task automatic send_element(input ntm_fixed_pkg::data_t f, input ntm_fixed_pkg::data_t i,
      input ntm_fixed_pkg::data_t a, input logic stray_start);
    ntm_fixed_pkg::data_t s_new;
    @(negedge CLK);
    START = stray_start;
    CLEAR = 1'b0;
    IN_STROBE = 1'b1;
    if (stray_start) SIZE_L = ntm_ctrl_pkg::len_t'(`NTM_MAX_L);
    F_IN = f;
    I_IN = i;
    A_IN = a;
    s_new = cell_update(f, ref_mem[cur_idx], i, a);
    ref_mem[cur_idx] = s_new;
    exp_q.push_back(s_new);
    last_q.push_back(cur_idx == cur_len - 1);
    cur_idx++;
    issued++;
  endtask

  // IN_STROBE while idle produces no result
  task automatic stray_strobe();
    @(negedge CLK);
    START = 1'b0;
    CLEAR = 1'b0;
    IN_STROBE = 1'b1;
    F_IN = rand_operand();
    I_IN = rand_operand();
    A_IN = rand_operand();
  endtask

  task automatic finish_vector();
    do begin
      idle(1);
    end while (!READY);
    vectors++;
  endtask

  ////////////////////
  // Result checks
  ////////////////////

  // Outputs sampled away from the rising edge
  always @(negedge CLK) begin
    if (READY) ready_seen++;
    if (S_OUT_STROBE) begin
      assert (exp_q.size() > 0) else begin
        errors++;
        $display("Result at %0t arrived with no element pending", $time);
      end
      if (exp_q.size() > 0) begin
        exp_val = exp_q.pop_front();
        exp_last = last_q.pop_front();
        checks++;
        assert (S_OUT == exp_val) else begin
          errors++;
          $display("CHECK FAILED at %0t: S_OUT got %0d expected %0d", $time, S_OUT, exp_val);
        end
        assert (READY == exp_last) else begin
          errors++;
          $display("CHECK FAILED at %0t: READY got %0b expected %0b", $time, READY, exp_last);
        end
      end
    end
  end

  // Budget grows with every issued element
  initial begin
    while (wd_cycles <= issued * 10 + 200) begin
      @(posedge CLK);
      wd_cycles++;
    end
    $display("Run timed out after %0d cycles with %0d elements issued", wd_cycles, issued);
    $display("sim failed");
    $finish;
  end

  ////////////////////
  // Test sequence
  ////////////////////

  initial begin
    void'($urandom(32'h348e));
    RST = 1'b1;
    START = 1'b0;
    SIZE_L = '0;
    CLEAR = 1'b0;
    IN_STROBE = 1'b0;
    I_IN = '0;
    F_IN = '0;
    A_IN = '0;
    for (int k = 0; k < `NTM_MAX_L; k++) ref_mem[k] = '0;
    repeat (5) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b0;
    idle(2);

    // Nonzero states ahead of the clear
    start_vector(4);
    for (int k = 0; k < 4; k++) send_element(rand_operand(), rand_operand(), rand_operand(), 1'b0);
    finish_vector();

    // From zero state s is just i*a
    clear_state();
    start_vector(4);
    for (int k = 0; k < 4; k++) send_element(rand_operand(), rand_operand(), rand_operand(), 1'b0);
    finish_vector();

    // Accumulate on the stored states
    start_vector(4);
    for (int k = 0; k < 4; k++) send_element(rand_operand(), rand_operand(), rand_operand(), 1'b0);
    finish_vector();

    // Saturation both ways
    clear_state();
    start_vector(2);
    send_element(FULL_POS, FULL_POS, FULL_POS, 1'b0);
    send_element(FULL_POS, FULL_POS, FULL_NEG, 1'b0);
    finish_vector();
    start_vector(2);
    send_element(FULL_POS, FULL_POS, FULL_POS, 1'b0);
    send_element(FULL_POS, FULL_NEG, FULL_POS, 1'b0);
    finish_vector();

    // Strobe while idle and START mid-vector
    stray_strobe();
    start_vector(3);
    send_element(rand_operand(), rand_operand(), rand_operand(), 1'b0);
    send_element(rand_operand(), rand_operand(), rand_operand(), 1'b1);
    send_element(rand_operand(), rand_operand(), rand_operand(), 1'b0);
    finish_vector();
    stray_strobe();
    idle(1);

    // Random lengths, gaps and clears
    repeat (20) begin
      if ($urandom_range(3, 0) == 0) clear_state();
      len = $urandom_range(`NTM_MAX_L, 1);
      start_vector(len);
      for (int k = 0; k < len; k++) begin
        idle($urandom_range(2, 0));
        send_element(rand_operand(), rand_operand(), rand_operand(), 1'b0);
      end
      finish_vector();
    end
    idle(6);

    assert (exp_q.size() == 0) else begin
      errors++;
      $display("%0d expected results never arrived", exp_q.size());
    end
    assert (ready_seen == vectors) else begin
      errors++;
      $display("READY pulsed %0d times for %0d vectors", ready_seen, vectors);
    end
    errors += dut0.sva0.fail_count;
    $display("errors: %0d, value checks: %0d, vectors: %0d", errors, checks, vectors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: flist.f
+incdir+hdl
hdl/ntm_fixed_pkg.sv
hdl/ntm_ctrl_pkg.sv
hdl/gate_stream_if.sv
hdl/state_vector_seq.sv
hdl/gate_product_stage.sv
hdl/gate_sum_stage.sv
hdl/state_gate_vector.sv
sim/state_gate_vector_sva.sv
sim/state_gate_vector_tb.sv

// File: Makefile
# Verilator build and run of the cell-state update testbench

TOP := state_gate_vector_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, search sim.log for the pass message"
	@echo "  clean  remove the build directory and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) +verilator+error+limit+1000 | tee sim.log
	grep -q "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log
